// ==== hw/trig_pkg.sv ====
/* trigger subsystem package
   channel count, record and bus widths, register map and the control word */
package trig_pkg;

  // channel digitizers behind the trigger manager
  localparam int num_chan = 5;
  // fill type carried to each channel
  localparam int fill_type_w = 2;

  // one trigger record word in the info FIFO
  localparam int rec_w = 64;
  // wishbone data width, a record is read as two halves
  localparam int wb_dw = 32;

  // wishbone word addresses
  localparam logic [1:0] reg_ctrl    = 2'd0;
  localparam logic [1:0] reg_status  = 2'd1;
  localparam logic [1:0] reg_fifo_lo = 2'd2;
  localparam logic [1:0] reg_fifo_hi = 2'd3;

  // one host write word, decoded by address
  // cfg at reg_ctrl, cmd at reg_status
  typedef union packed {
    struct packed {
      logic [wb_dw-num_chan-fill_type_w-1:0] rsvd;
      logic [fill_type_w-1:0]                fill_type;
      logic [num_chan-1:0]                   chan_en;
    } cfg;
    struct packed {
      logic [wb_dw-3:0] rsvd;
      logic             reset_trig_timestamp;
      logic             reset_trig_num;
    } cmd;
  } ctrl_word_u;

endpackage

// ==== hw/trigger_manager.sv ====
`timescale 1ns/1ps
/* trigger manager FSM
   fans a trigger out to the enabled channels, waits for done, then writes
   the trigger number and timestamp into the info FIFO */
module trigger_manager
  import trig_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  // counter clears from the command host
  input  logic                        reset_trig_timestamp,
  input  logic                        reset_trig_num,
  // trigger and channel setup
  input  logic                        trigger,
  input  logic [num_chan-1:0]         chan_en,
  input  logic [fill_type_w-1:0]      fill_type,
  // channel digitizers
  input  logic [num_chan-1:0]         acq_done,
  output logic [num_chan*fill_type_w-1:0] acq_enable,
  output logic [num_chan-1:0]         acq_trig,
  // info FIFO, valid/ready
  input  logic                        fifo_ready,
  output logic                        fifo_valid,
  output logic [rec_w-1:0]            data_to_fifo
);

  // one-hot state bit positions
  localparam int st_idle      = 0;
  localparam int st_fill      = 1;
  localparam int st_store_num = 2;
  localparam int st_store_ts  = 3;

  logic [3:0]       state;
  logic [3:0]       state_next;
  // triggers seen since the last number clear
  logic [rec_w-1:0] trig_num;
  // counter value captured with the last trigger
  logic [rec_w-1:0] trig_timestamp;
  // clock ticks since the last timestamp clear
  logic [rec_w-1:0] counter;
  logic             fill_done;
  logic             word_taken;
  logic             trig_accept;

  // all enabled channels report done, true at once when nothing is enabled
  assign fill_done   = (acq_done == acq_trig);
  assign word_taken  = fifo_valid && fifo_ready;
  // triggers outside idle are dropped
  assign trig_accept = state[st_idle] && trigger;

  // channel outputs only live while filling
  always_comb begin
    acq_trig   = '0;
    acq_enable = '0;
    if (state[st_fill]) begin
      acq_trig   = chan_en;
      acq_enable = {num_chan{fill_type}};
    end
  end

  // next state
  always_comb begin
    state_next = '0;
    unique case (1'b1)
      state[st_idle]: begin
        if (trigger) begin
          state_next[st_fill] = 1'b1;
        end else begin
          state_next[st_idle] = 1'b1;
        end
      end
      // wait for the channels
      state[st_fill]: begin
        if (fill_done) begin
          state_next[st_store_num] = 1'b1;
        end else begin
          state_next[st_fill] = 1'b1;
        end
      end
      // trigger number goes first
      state[st_store_num]: begin
        if (word_taken) begin
          state_next[st_store_ts] = 1'b1;
        end else begin
          state_next[st_store_num] = 1'b1;
        end
      end
      // then the timestamp, back to idle once it is in
      state[st_store_ts]: begin
        if (word_taken) begin
          state_next[st_idle] = 1'b1;
        end else begin
          state_next[st_store_ts] = 1'b1;
        end
      end
      default: state_next[st_idle] = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      // idle bit only
      state <= 4'b0001;
    end else begin
      state <= state_next;
    end
  end

  // free running tick count, zero in the cycle after a clear
  always_ff @(posedge clk) begin
    if (reset || reset_trig_timestamp) begin
      counter <= '0;
    end else begin
      counter <= counter + 1'b1;
    end
  end

  // first accepted trigger after a clear is number 1
  always_ff @(posedge clk) begin
    if (reset || reset_trig_num) begin
      trig_num <= '0;
    end else if (trig_accept) begin
      trig_num <= trig_num + 1'b1;
    end
  end

  // counter as seen on the trigger edge
  always_ff @(posedge clk) begin
    if (trig_accept) begin
      trig_timestamp <= counter;
    end
  end

  // valid follows the store states
  always_ff @(posedge clk) begin
    if (reset) begin
      fifo_valid <= 1'b0;
    end else begin
      fifo_valid <= state_next[st_store_num] || state_next[st_store_ts];
    end
  end

  // word only changes when the state moves, so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (state[st_fill] && fill_done) begin
      data_to_fifo <= trig_num;
    end else if (state[st_store_num] && word_taken) begin
      data_to_fifo <= trig_timestamp;
    end
  end

  // channels only see a trigger while the FSM is filling
  a_trig_only_in_fill: assert property (@(posedge clk) disable iff (reset)
    !state[st_fill] |-> acq_trig == '0);

  // a stalled record word keeps its value until the FIFO takes it
  a_hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
    fifo_valid && !fifo_ready |=> fifo_valid && $stable(data_to_fifo));

endmodule

// ==== hw/trig_info_fifo.sv ====
`timescale 1ns/1ps
/* trigger info FIFO
   circular buffer of 64-bit trigger records with an occupancy level */
module trig_info_fifo
  import trig_pkg::*;
#(
  parameter int depth = 8
) (
  input  logic                       clk,
  input  logic                       reset,
  // write side, valid/ready
  input  logic                       push,
  input  logic [rec_w-1:0]           wr_data,
  output logic                       ready,
  // read side, oldest word shown
  input  logic                       pop,
  output logic [rec_w-1:0]           rd_data,
  output logic                       empty,
  output logic [$clog2(depth+1)-1:0] level
);

  localparam int aw = (depth > 1) ? $clog2(depth) : 1;

  logic [rec_w-1:0] mem [depth];
  logic [aw-1:0]    wr_ptr;
  logic [aw-1:0]    rd_ptr;
  logic             do_push;
  logic             do_pop;

  // pointer step with wrap, depth need not be a power of two
  function automatic logic [aw-1:0] next_ptr(input logic [aw-1:0] p);
    if (p == aw'(depth - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign ready   = (level != depth);
  assign empty   = (level == '0);
  assign do_push = push && ready;
  // pop on an empty buffer is ignored
  assign do_pop  = pop && !empty;
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // level moves only when exactly one side transfers
      case ({do_push, do_pop})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  // the register block only pops when it has seen a word
  a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
    pop |-> !empty);

  // a push held off by a full buffer keeps its word until it is taken
  a_push_held_full: assert property (@(posedge clk) disable iff (reset)
    push && !ready |=> push && $stable(wr_data));

endmodule

// ==== hw/trig_wb_regs.sv ====
`timescale 1ns/1ps
/* trigger register block
   wishbone classic slave for channel setup, counter commands, status and
   readout of the info FIFO in two halves */
module trig_wb_regs
  import trig_pkg::*;
#(
  parameter int depth = 8
) (
  input  logic                       clk,
  input  logic                       reset,
  // wishbone classic slave
  input  logic                       wb_cyc,
  input  logic                       wb_stb,
  input  logic                       wb_we,
  input  logic [1:0]                 wb_adr,
  input  logic [wb_dw-1:0]           wb_dat_w,
  output logic [wb_dw-1:0]           wb_dat_r,
  output logic                       wb_ack,
  // info FIFO read side
  input  logic [2*wb_dw-1:0]         rd_data,
  input  logic                       empty,
  input  logic [$clog2(depth+1)-1:0] level,
  output logic                       pop,
  // to the trigger manager
  output logic [num_chan-1:0]        chan_en,
  output logic [fill_type_w-1:0]     fill_type,
  output logic                       reset_trig_num,
  output logic                       reset_trig_timestamp
);

  localparam int lw = $clog2(depth + 1);

  // first cycle of a strobed access, the one ack answers
  logic             access;
  logic             wr_ctrl;
  logic             wr_cmd;
  ctrl_word_u       wr_word;
  ctrl_word_u       cfg_rd;
  logic [wb_dw-1:0] rd_mux;

  assign access  = wb_cyc && wb_stb && !wb_ack;
  assign wr_word = wb_dat_w;
  assign wr_ctrl = access && wb_we && (wb_adr == reg_ctrl);
  // writes to the status address are commands
  assign wr_cmd  = access && wb_we && (wb_adr == reg_status);

  // high half read consumes the record word
  assign pop = access && !wb_we && (wb_adr == reg_fifo_hi) && !empty;

  // config read back in the same layout it is written
  always_comb begin
    cfg_rd               = '0;
    cfg_rd.cfg.chan_en   = chan_en;
    cfg_rd.cfg.fill_type = fill_type;
  end

  // read select
  always_comb begin
    rd_mux = '0;
    case (wb_adr)
      reg_ctrl: rd_mux = cfg_rd;
      reg_status: begin
        rd_mux[lw-1:0]    = level;
        rd_mux[wb_dw-1]   = empty;
      end
      // empty FIFO reads as zero
      reg_fifo_lo: begin
        if (!empty) begin
          rd_mux = rd_data[wb_dw-1:0];
        end
      end
      reg_fifo_hi: begin
        if (!empty) begin
          rd_mux = rd_data[2*wb_dw-1:wb_dw];
        end
      end
      default: rd_mux = '0;
    endcase
  end

  // ack, config and command pulses
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack               <= 1'b0;
      chan_en              <= '0;
      fill_type            <= '0;
      reset_trig_num       <= 1'b0;
      reset_trig_timestamp <= 1'b0;
    end else begin
      wb_ack               <= access;
      // pulses live for the ack cycle only
      reset_trig_num       <= wr_cmd && wr_word.cmd.reset_trig_num;
      reset_trig_timestamp <= wr_cmd && wr_word.cmd.reset_trig_timestamp;
      if (wr_ctrl) begin
        chan_en   <= wr_word.cfg.chan_en;
        fill_type <= wr_word.cfg.fill_type;
      end
    end
  end

  // data sampled before the pop edge moves the FIFO on
  always_ff @(posedge clk) begin
    if (access && !wb_we) begin
      wb_dat_r <= rd_mux;
    end
  end

  // ack only answers a live strobe
  a_ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
    wb_ack |-> wb_cyc && wb_stb);

  // one ack per access, never back to back
  a_ack_single: assert property (@(posedge clk) disable iff (reset)
    wb_ack |=> !wb_ack);

endmodule

// ==== hw/trig_subsystem.sv ====
`timescale 1ns/1ps
/* trigger subsystem top
   trigger manager, info FIFO and wishbone register block */
module trig_subsystem
  import trig_pkg::*;
#(
  parameter int fifo_depth = 8
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            trigger,
  // channel digitizers
  input  logic [num_chan-1:0]             acq_done,
  output logic [num_chan-1:0]             acq_trig,
  output logic [num_chan*fill_type_w-1:0] acq_enable,
  // wishbone classic slave
  input  logic                            wb_cyc,
  input  logic                            wb_stb,
  input  logic                            wb_we,
  input  logic [1:0]                      wb_adr,
  input  logic [wb_dw-1:0]                wb_dat_w,
  output logic [wb_dw-1:0]                wb_dat_r,
  output logic                            wb_ack
);

  localparam int lw = $clog2(fifo_depth + 1);

  // register block to manager
  logic [num_chan-1:0]    chan_en;
  logic [fill_type_w-1:0] fill_type;
  logic                   reset_trig_num;
  logic                   reset_trig_timestamp;
  // manager to FIFO
  logic                   fifo_valid;
  logic                   fifo_ready;
  logic [rec_w-1:0]       data_to_fifo;
  // FIFO to register block
  logic                   pop;
  logic [rec_w-1:0]       rd_data;
  logic                   empty;
  logic [lw-1:0]          level;

  trigger_manager trigger_manager_inst (
    .clk                  (clk),
    .reset                (reset),
    .reset_trig_timestamp (reset_trig_timestamp),
    .reset_trig_num       (reset_trig_num),
    .trigger              (trigger),
    .chan_en              (chan_en),
    .fill_type            (fill_type),
    .acq_done             (acq_done),
    .acq_enable           (acq_enable),
    .acq_trig             (acq_trig),
    .fifo_ready           (fifo_ready),
    .fifo_valid           (fifo_valid),
    .data_to_fifo         (data_to_fifo)
  );

  trig_info_fifo #(
    .depth (fifo_depth)
  ) trig_info_fifo_inst (
    .clk     (clk),
    .reset   (reset),
    .push    (fifo_valid),
    .wr_data (data_to_fifo),
    .ready   (fifo_ready),
    .pop     (pop),
    .rd_data (rd_data),
    .empty   (empty),
    .level   (level)
  );

  trig_wb_regs #(
    .depth (fifo_depth)
  ) trig_wb_regs_inst (
    .clk                  (clk),
    .reset                (reset),
    .wb_cyc               (wb_cyc),
    .wb_stb               (wb_stb),
    .wb_we                (wb_we),
    .wb_adr               (wb_adr),
    .wb_dat_w             (wb_dat_w),
    .wb_dat_r             (wb_dat_r),
    .wb_ack               (wb_ack),
    .rd_data              (rd_data),
    .empty                (empty),
    .level                (level),
    .pop                  (pop),
    .chan_en              (chan_en),
    .fill_type            (fill_type),
    .reset_trig_num       (reset_trig_num),
    .reset_trig_timestamp (reset_trig_timestamp)
  );

endmodule

// ==== bench/tb_trig_subsystem.sv ====
`timescale 1ns/1ps
/* trigger subsystem testbench
   channel digitizer model, wishbone host, reference records and checks */
module tb_trig_subsystem
  import trig_pkg::*;
();

  // sum of the test lengths with margin
  localparam int timeout_cycles = 4000;

  logic                            clk = 1'b0;
  logic                            reset;
  logic                            trigger;
  logic [num_chan-1:0]             acq_done = '0;
  logic [num_chan-1:0]             acq_trig;
  logic [num_chan*fill_type_w-1:0] acq_enable;
  logic                            wb_cyc;
  logic                            wb_stb;
  logic                            wb_we;
  logic [1:0]                      wb_adr;
  logic [wb_dw-1:0]                wb_dat_w;
  logic [wb_dw-1:0]                wb_dat_r;
  logic                            wb_ack;

  // posedge count, also the timeout counter
  longint edge_cnt = 0;
  // edge on which the DUT counter was last cleared
  longint ts_clear;
  // accepted triggers since the last number clear
  longint trig_count = 0;
  longint ack_edge;
  int     err_cnt = 0;
  logic [31:0] lfsr = 32'd99575;
  // channel model state
  logic [num_chan-1:0] busy = '0;
  int     delay [num_chan];
  // host view of the configuration
  logic [num_chan-1:0]    cfg_en = '0;
  logic [fill_type_w-1:0] cfg_fill = '0;
  // expected and read back record words
  logic [rec_w-1:0] exp_q [$];
  string            exp_name_q [$];
  logic [rec_w-1:0] got_q [$];

  trig_subsystem #(
    .fifo_depth (4)
  ) trig_subsystem_inst (
    .clk        (clk),
    .reset      (reset),
    .trigger    (trigger),
    .acq_done   (acq_done),
    .acq_trig   (acq_trig),
    .acq_enable (acq_enable),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    edge_cnt <= edge_cnt + 1;
    if (edge_cnt == timeout_cycles) begin
      $display("timeout, the run did not finish within %0d cycles", timeout_cycles);
      $display("run ended with %0d errors", err_cnt);
      $display("TEST FAIL");
      $finish;
    end
  end

  // 32-bit fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // record pair {number, timestamp}, the counter reads 0 the cycle after a clear
  function automatic logic [127:0] expected_record(input longint num,
                                                   input longint trig_edge,
                                                   input longint clear_edge);
    return {64'(num), 64'(trig_edge - clear_edge - 1)};
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    if (exp !== act) begin
      err_cnt++;
      $display("ERROR %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  // channel digitizers, done after 1 to 8 cycles, held until trig falls
  always @(negedge clk) begin
    if (!reset && acq_trig != '0 && busy == '0) begin
      check_value("acq_trig mask", cfg_en, acq_trig);
      check_value("acq_enable", {num_chan{cfg_fill}}, acq_enable);
    end
    for (int i = 0; i < num_chan; i++) begin
      if (reset || !acq_trig[i]) begin
        acq_done[i] = 1'b0;
        busy[i]     = 1'b0;
      end else if (!busy[i]) begin
        busy[i]  = 1'b1;
        delay[i] = int'(rand_bits(3)) + 1;
      end else if (delay[i] > 1) begin
        delay[i] = delay[i] - 1;
      end else begin
        acq_done[i] = 1'b1;
      end
    end
  end

  // compare each record word read back with the reference queue
  always @(negedge clk) begin
    while (got_q.size() > 0) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("record word %0h was read but no record was expected", got_q.pop_front());
      end else begin
        check_value(exp_name_q.pop_front(), exp_q.pop_front(), got_q.pop_front());
      end
    end
  end

  // one classic access, ack must come after one cycle and only once
  // strobe stays up over the edge that samples ack
  task automatic wb_access(input logic we, input logic [1:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    int n;
    n = 0;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    do begin
      @(negedge clk);
      n++;
    end while (!wb_ack);
    ack_edge = edge_cnt;
    rdat     = wb_dat_r;
    check_value("wb ack latency", 1, n);
    @(negedge clk);
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    check_value("wb ack single", 0, wb_ack);
  endtask

  task automatic write_config(input logic [num_chan-1:0] en, input logic [1:0] ft);
    logic [31:0] rd;
    wb_access(1'b1, reg_ctrl, {25'd0, ft, en}, rd);
    cfg_en   = en;
    cfg_fill = ft;
  endtask

  // bit 0 clears the trigger number, bit 1 the timestamp, both at the end of ack
  task automatic send_command(input logic [1:0] cmd);
    logic [31:0] rd;
    wb_access(1'b1, reg_status, {30'd0, cmd}, rd);
    if (cmd[0]) begin
      trig_count = 0;
    end
    if (cmd[1]) begin
      ts_clear = ack_edge + 1;
    end
  endtask

  task automatic fire_trigger(input bit accepted, input string tag);
    logic [127:0] rec;
    @(negedge clk);
    trigger = 1'b1;
    if (accepted) begin
      trig_count++;
      rec = expected_record(trig_count, edge_cnt + 1, ts_clear);
      exp_q.push_back(rec[127:64]);
      exp_name_q.push_back({tag, " number"});
      exp_q.push_back(rec[63:0]);
      exp_name_q.push_back({tag, " timestamp"});
    end
    @(negedge clk);
    trigger = 1'b0;
  endtask

  task automatic wait_level(input int min_level);
    logic [31:0] rd;
    do begin
      wb_access(1'b0, reg_status, '0, rd);
    end while (int'(rd[30:0]) < min_level);
  endtask

  // two words, each read low half then high half
  task automatic pop_record();
    logic [31:0] lo;
    logic [31:0] hi;
    wait_level(2);
    for (int w = 0; w < 2; w++) begin
      wb_access(1'b0, reg_fifo_lo, '0, lo);
      wb_access(1'b0, reg_fifo_hi, '0, hi);
      got_q.push_back({hi, lo});
    end
  endtask

  initial begin
    logic [31:0] rd;
    reset    = 1'b1;
    trigger  = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset    = 1'b0;
    ts_clear = edge_cnt;

    // register access on an empty FIFO
    wb_access(1'b0, reg_status, '0, rd);
    check_value("status empty", 32'h8000_0000, rd);
    wb_access(1'b0, reg_fifo_lo, '0, rd);
    check_value("empty fifo lo", 0, rd);
    wb_access(1'b0, reg_fifo_hi, '0, rd);
    check_value("empty fifo hi", 0, rd);
    wb_access(1'b1, reg_ctrl, 32'hffff_ff6a, rd);
    cfg_en   = 5'h0a;
    cfg_fill = 2'd3;
    wb_access(1'b0, reg_ctrl, '0, rd);
    check_value("ctrl readback", 32'h6a, rd);

    // basic trigger, all channels
    write_config(5'h1f, 2'd2);
    fire_trigger(1'b1, "basic");
    wait_level(2);
    wb_access(1'b0, reg_status, '0, rd);
    check_value("basic level", 32'd2, rd);
    pop_record();

    // random masks, fill types and done delays
    for (int i = 0; i < 6; i++) begin
      write_config(5'(rand_bits(5)), 2'(rand_bits(2)));
      fire_trigger(1'b1, $sformatf("seq %0d", i));
      pop_record();
    end

    // counter clears, separately then together
    send_command(2'b01);
    fire_trigger(1'b1, "num clear");
    pop_record();
    send_command(2'b10);
    fire_trigger(1'b1, "ts clear");
    pop_record();
    send_command(2'b11);
    fire_trigger(1'b1, "both clear");
    pop_record();

    // two records fill the depth 4 FIFO, the third stalls
    write_config(5'h1f, 2'd1);
    fire_trigger(1'b1, "bp a");
    wait_level(2);
    fire_trigger(1'b1, "bp b");
    wait_level(4);
    fire_trigger(1'b1, "bp c");
    while (acq_trig != '0) begin
      @(negedge clk);
    end
    // manager is stuck on the number word, this one is dropped
    fire_trigger(1'b0, "bp d");
    wb_access(1'b0, reg_status, '0, rd);
    check_value("bp full level", 32'd4, rd);
    repeat (3) begin
      pop_record();
    end
    wb_access(1'b0, reg_status, '0, rd);
    check_value("bp drained", 32'h8000_0000, rd);

    repeat (2) @(negedge clk);
    if (exp_q.size() != 0) begin
      err_cnt++;
      $display("%0d expected record words were never read back", exp_q.size());
    end
    $display("run finished with %0d errors", err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== src.f ====
hw/trig_pkg.sv
hw/trigger_manager.sv
hw/trig_info_fifo.sv
hw/trig_wb_regs.sv
hw/trig_subsystem.sv
bench/tb_trig_subsystem.sv

// ==== Bender.yml ====
package:
  name: trig_subsystem

sources:
  - files:
      - hw/trig_pkg.sv
      - hw/trigger_manager.sv
      - hw/trig_info_fifo.sv
      - hw/trig_wb_regs.sv
      - hw/trig_subsystem.sv
  - target: simulation
    files:
      - bench/tb_trig_subsystem.sv
